//--- frame_fifo_top.f
+incdir+logic
logic/frame_fifo_pkg.sv
logic/frame_ram_wr_if.sv
logic/frame_fifo_ctrl.sv
logic/frame_fifo_ram.sv
logic/frame_out_stage.sv
logic/frame_stats.sv
logic/frame_fifo_top.sv
verif/frame_fifo_assertions.sv
verif/frame_fifo_tb.sv

//--- logic/frame_fifo_consts.svh
// frame FIFO constants
// depth, beat width and statistics counter width

`ifndef FRAME_FIFO_CONSTS_SVH
`define FRAME_FIFO_CONSTS_SVH

// address bits, 16 entries
// pointers carry one extra wrap bit on top of this
`define FIFO_ADDR_WIDTH 4

// payload width of one beat
// the ram keeps one more bit for last
`define FIFO_DATA_WIDTH 8

// width of each saturating frame counter
`define FIFO_STAT_WIDTH 16

`endif

//--- logic/frame_fifo_ctrl.sv
// frame FIFO control
// pointer bookkeeping, frame commit and rollback, drop handling and status report

`timescale 1ns/1ps
`default_nettype none

`include "frame_fifo_consts.svh"

module frame_fifo_ctrl (
    input  wire logic                          clk,
    input  wire logic                          rst,
    frame_ram_wr_if.ctrl                       wr,
    input  wire logic [`FIFO_DATA_WIDTH-1:0]   in_data,
    input  wire logic                          in_valid,
    input  wire logic                          in_last,
    input  wire logic                          in_user,
    output      logic                          in_ready,
    input  wire logic                          pop_req,
    output      logic                          rd_en,
    output      logic [`FIFO_ADDR_WIDTH-1:0]   rd_addr,
    output      logic                          status_valid,
    output      frame_fifo_pkg::frame_status_t status_code
);

    import frame_fifo_pkg::*;

    localparam int AW = `FIFO_ADDR_WIDTH;

    // committed end of the last good frame
    logic [AW:0] wr_ptr_commit;
    // write position inside the frame in progress
    logic [AW:0] wr_ptr_cur;
    logic [AW:0] rd_ptr;
    wr_state_t   wr_state;
    logic        in_ready_reg;
    logic        full;
    logic        full_cur;
    logic        empty;
    logic        accept;
    logic        store_beat;

    // no room for the next beat: current pointer one lap ahead of read
    assign full = (wr_ptr_cur[AW] != rd_ptr[AW]) &&
                  (wr_ptr_cur[AW-1:0] == rd_ptr[AW-1:0]);
    // frame alone already fills the whole memory
    assign full_cur = (wr_ptr_cur[AW] != wr_ptr_commit[AW]) &&
                      (wr_ptr_cur[AW-1:0] == wr_ptr_commit[AW-1:0]);
    // only committed frames are visible to the read side
    assign empty = (wr_ptr_commit == rd_ptr);

    // source never stalls once out of reset
    assign in_ready = in_ready_reg;
    assign accept = in_valid && in_ready_reg;
    assign store_beat = accept && (wr_state == WR_STORE) && !full && !full_cur;

    // ram write port
    assign wr.wr_en   = store_beat;
    assign wr.wr_addr = wr_ptr_cur[AW-1:0];
    assign wr.wr_data = in_data;
    assign wr.wr_last = in_last;

    // read request answered only when a committed beat waits
    assign rd_en   = pop_req && !empty;
    assign rd_addr = rd_ptr[AW-1:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_ready_reg <= 1'b0;
        end else begin
            in_ready_reg <= 1'b1;
        end
    end

    // write side and frame status
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr_commit <= '0;
            wr_ptr_cur    <= '0;
            wr_state      <= WR_STORE;
            status_valid  <= 1'b0;
            status_code   <= FRAME_GOOD;
        end else begin
            // status is a single-cycle pulse
            status_valid <= 1'b0;
            if (store_beat) begin
                if (in_last) begin
                    status_valid <= 1'b1;
                    if (in_user) begin
                        // bad frame, forget everything written
                        wr_ptr_cur  <= wr_ptr_commit;
                        status_code <= FRAME_BAD;
                    end else begin
                        // good frame, publish it to the read side
                        wr_ptr_cur    <= wr_ptr_cur + 1'b1;
                        wr_ptr_commit <= wr_ptr_cur + 1'b1;
                        status_code   <= FRAME_GOOD;
                    end
                end else begin
                    wr_ptr_cur <= wr_ptr_cur + 1'b1;
                end
            end else if (accept) begin
                // out of space or already dropping
                if (in_last) begin
                    wr_ptr_cur   <= wr_ptr_commit;
                    wr_state     <= WR_STORE;
                    status_valid <= 1'b1;
                    status_code  <= FRAME_OVERFLOW;
                end else begin
                    wr_state <= WR_DROP;
                end
            end
        end
    end

    // read pointer, one entry per granted request
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_ptr <= '0;
        end else if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- logic/frame_fifo_pkg.sv
// frame FIFO types
// write-side state and finished-frame status opcode

`default_nettype none

package frame_fifo_pkg;

    // write side FSM
    // store: beats go to the ram
    // drop: rest of the frame is thrown away
    typedef enum logic [0:0] {
        WR_STORE = 1'b0,
        WR_DROP  = 1'b1
    } wr_state_t;

    // outcome of a frame, reported once on its last beat
    typedef enum logic [1:0] {
        FRAME_GOOD     = 2'd0,
        FRAME_BAD      = 2'd1,
        FRAME_OVERFLOW = 2'd2
    } frame_status_t;

endpackage

`default_nettype wire

//--- logic/frame_fifo_ram.sv
// frame FIFO storage
// 16-entry beat memory with a registered read port that holds under back-pressure

`timescale 1ns/1ps
`default_nettype none

`include "frame_fifo_consts.svh"

module frame_fifo_ram (
    input  wire logic                        clk,
    input  wire logic                        rst,
    frame_ram_wr_if.ram                      wr,
    input  wire logic                        rd_en,
    input  wire logic [`FIFO_ADDR_WIDTH-1:0] rd_addr,
    output      logic [`FIFO_DATA_WIDTH-1:0] out_data,
    output      logic                        out_last
);

    localparam int DEPTH = 2 ** `FIFO_ADDR_WIDTH;

    // last flag in the top bit, payload below
    logic [`FIFO_DATA_WIDTH:0] mem [DEPTH];
    logic [`FIFO_DATA_WIDTH:0] rd_reg;

    always_ff @(posedge clk) begin
        if (wr.wr_en) begin
            mem[wr.wr_addr] <= {wr.wr_last, wr.wr_data};
        end
    end

    // output beat only moves on a granted read
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_reg <= '0;
        end else if (rd_en) begin
            rd_reg <= mem[rd_addr];
        end
    end

    assign out_last = rd_reg[`FIFO_DATA_WIDTH];
    assign out_data = rd_reg[`FIFO_DATA_WIDTH-1:0];

endmodule

`default_nettype wire

//--- logic/frame_fifo_top.sv
// store-and-forward frame FIFO, top level
// control, storage, output stage and frame statistics

`timescale 1ns/1ps
`default_nettype none

`include "frame_fifo_consts.svh"

module frame_fifo_top (
    input  wire logic                        clk,
    input  wire logic                        rst,
    // input stream
    input  wire logic [`FIFO_DATA_WIDTH-1:0] in_data,
    input  wire logic                        in_valid,
    input  wire logic                        in_last,
    input  wire logic                        in_user,
    output      logic                        in_ready,
    // output stream
    output      logic [`FIFO_DATA_WIDTH-1:0] out_data,
    output      logic                        out_valid,
    input  wire logic                        out_ready,
    output      logic                        out_last,
    // frame counters
    output      logic [`FIFO_STAT_WIDTH-1:0] good_frames,
    output      logic [`FIFO_STAT_WIDTH-1:0] bad_frames,
    output      logic [`FIFO_STAT_WIDTH-1:0] dropped_frames
);

    import frame_fifo_pkg::*;

    logic                        pop_req;
    logic                        rd_en;
    logic [`FIFO_ADDR_WIDTH-1:0] rd_addr;
    logic                        status_valid;
    frame_status_t               status_code;

    frame_ram_wr_if ram_wr ();

    frame_fifo_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .wr           (ram_wr.ctrl),
        .in_data      (in_data),
        .in_valid     (in_valid),
        .in_last      (in_last),
        .in_user      (in_user),
        .in_ready     (in_ready),
        .pop_req      (pop_req),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .status_valid (status_valid),
        .status_code  (status_code)
    );

    frame_fifo_ram u_ram (
        .clk      (clk),
        .rst      (rst),
        .wr       (ram_wr.ram),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .out_data (out_data),
        .out_last (out_last)
    );

    frame_out_stage u_out (
        .clk       (clk),
        .rst       (rst),
        .out_ready (out_ready),
        .rd_en     (rd_en),
        .out_valid (out_valid),
        .pop_req   (pop_req)
    );

    frame_stats u_stats (
        .clk            (clk),
        .rst            (rst),
        .status_valid   (status_valid),
        .status_code    (status_code),
        .good_frames    (good_frames),
        .bad_frames     (bad_frames),
        .dropped_frames (dropped_frames)
    );

endmodule

`default_nettype wire

//--- logic/frame_out_stage.sv
// frame FIFO output stage
// owns out_valid and requests the next beat when the output register frees up

`timescale 1ns/1ps
`default_nettype none

module frame_out_stage (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic out_ready,
    input  wire logic rd_en,
    output      logic out_valid,
    output      logic pop_req
);

    logic out_valid_reg;

    // register is empty or its beat leaves on this edge
    assign pop_req = out_ready || !out_valid_reg;
    assign out_valid = out_valid_reg;

    // refill from the grant, hold while stalled
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid_reg <= 1'b0;
        end else if (pop_req) begin
            out_valid_reg <= rd_en;
        end
    end

endmodule

`default_nettype wire

//--- logic/frame_ram_wr_if.sv
// frame RAM write port
// one beat plus its last flag per write cycle

`timescale 1ns/1ps
`default_nettype none

`include "frame_fifo_consts.svh"

interface frame_ram_wr_if;

    // write strobe, sampled on the rising edge
    logic                        wr_en;
    // entry index, no wrap bit
    logic [`FIFO_ADDR_WIDTH-1:0] wr_addr;
    // beat payload
    logic [`FIFO_DATA_WIDTH-1:0] wr_data;
    // end of frame marker stored next to the payload
    logic                        wr_last;

    // control side drives the port
    modport ctrl (
        output wr_en,
        output wr_addr,
        output wr_data,
        output wr_last
    );

    // storage side only listens
    modport ram (
        input wr_en,
        input wr_addr,
        input wr_data,
        input wr_last
    );

endinterface

`default_nettype wire

//--- logic/frame_stats.sv
// frame FIFO statistics
// saturating counts of forwarded, bad and overflow-dropped frames

`timescale 1ns/1ps
`default_nettype none

`include "frame_fifo_consts.svh"

module frame_stats (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          status_valid,
    input  wire frame_fifo_pkg::frame_status_t status_code,
    output      logic [`FIFO_STAT_WIDTH-1:0]   good_frames,
    output      logic [`FIFO_STAT_WIDTH-1:0]   bad_frames,
    output      logic [`FIFO_STAT_WIDTH-1:0]   dropped_frames
);

    import frame_fifo_pkg::*;

    // decoded increment strobes, one stage after the status pulse
    logic inc_good;
    logic inc_bad;
    logic inc_drop;

    // stick at all ones instead of wrapping
    function automatic logic [`FIFO_STAT_WIDTH-1:0] sat_inc(
        input logic [`FIFO_STAT_WIDTH-1:0] cnt
    );
        if (&cnt) begin
            return cnt;
        end
        return cnt + 1'b1;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            inc_good <= 1'b0;
            inc_bad  <= 1'b0;
            inc_drop <= 1'b0;
        end else begin
            inc_good <= status_valid && (status_code == FRAME_GOOD);
            inc_bad  <= status_valid && (status_code == FRAME_BAD);
            inc_drop <= status_valid && (status_code == FRAME_OVERFLOW);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            good_frames    <= '0;
            bad_frames     <= '0;
            dropped_frames <= '0;
        end else begin
            if (inc_good) begin
                good_frames <= sat_inc(good_frames);
            end
            if (inc_bad) begin
                bad_frames <= sat_inc(bad_frames);
            end
            if (inc_drop) begin
                dropped_frames <= sat_inc(dropped_frames);
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/frame_fifo_assertions.sv
// frame FIFO protocol assertions
// output hold under back-pressure, reset values, in_ready and idle write state

`timescale 1ns/1ps
`default_nettype none

`include "frame_fifo_consts.svh"

module frame_fifo_assertions (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        in_valid,
    input  wire logic                        in_last,
    input  wire logic                        in_ready,
    input  wire logic                        out_valid,
    input  wire logic                        out_ready,
    input  wire logic [`FIFO_DATA_WIDTH-1:0] out_data,
    input  wire logic                        out_last,
    input  wire frame_fifo_pkg::wr_state_t   wr_state
);

    import frame_fifo_pkg::*;

    // read back by the testbench for the closing line
    int unsigned assert_failures = 0;

    // a frame has started and its last beat is not yet accepted
    logic in_frame;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_frame <= 1'b0;
        end else if (in_valid && in_ready) begin
            in_frame <= !in_last;
        end
    end

    // stalled beat must stay put
    out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
        else begin
            assert_failures++;
            $error("output beat changed while out_ready was low");
        end

    // nothing on the output during and right after reset
    out_idle_reset: assert property (@(posedge clk) (rst || $fell(rst)) |-> !out_valid)
        else begin
            assert_failures++;
            $error("out_valid high during or right after reset");
        end

    // source is never stalled
    ready_high: assert property (@(posedge clk) !rst && !$past(rst) |-> in_ready)
        else begin
            assert_failures++;
            $error("in_ready dropped after reset release");
        end

    // between frames the write side is back to storing
    store_when_idle: assert property (@(posedge clk) disable iff (rst)
        !in_frame |-> wr_state == WR_STORE)
        else begin
            assert_failures++;
            $error("write state not WR_STORE between frames");
        end

endmodule

bind frame_fifo_top frame_fifo_assertions u_assert (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_last   (in_last),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .out_last  (out_last),
    .wr_state  (u_ctrl.wr_state)
);

`default_nettype wire

//--- verif/frame_fifo_tb.sv
// frame FIFO testbench
// random frames against a reference queue, counter checks and a watchdog

`timescale 1ns/1ps
`default_nettype none

`include "frame_fifo_consts.svh"

module frame_fifo_tb;

    logic                        clk;
    logic                        rst;
    logic [`FIFO_DATA_WIDTH-1:0] in_data;
    logic                        in_valid;
    logic                        in_last;
    logic                        in_user;
    logic                        in_ready;
    logic [`FIFO_DATA_WIDTH-1:0] out_data;
    logic                        out_valid;
    logic                        out_ready;
    logic                        out_last;
    logic [`FIFO_STAT_WIDTH-1:0] good_frames;
    logic [`FIFO_STAT_WIDTH-1:0] bad_frames;
    logic [`FIFO_STAT_WIDTH-1:0] dropped_frames;

    // expected beats with the last flag on top
    logic [`FIFO_DATA_WIDTH:0] ref_q [$];
    logic [31:0]               rng_state = 32'h8c6f;
    logic                      ready_random = 1'b0;
    int                        check_errors = 0;
    int                        beats_sent = 0;
    int                        stall_cycles = 0;
    int                        cycle_count = 0;
    int                        exp_good = 0;
    int                        exp_bad = 0;
    int                        exp_dropped = 0;

    frame_fifo_top DUT (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic draw(output logic [31:0] value);
        rng_state = xorshift32(rng_state);
        value = rng_state;
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[ERROR] %0t ns %s expected %0h got %0h", $time, name, expected, actual);
        check_errors++;
    endtask

    // out_ready redrawn each clock when back-pressure is on
    task automatic tick();
        logic [31:0] r;
        @(posedge clk);
        if (ready_random) begin
            draw(r);
            out_ready <= r[0];
            if (!r[0]) begin
                stall_cycles++;
            end
        end else begin
            out_ready <= 1'b1;
        end
    endtask

    task automatic send_frame(input int len, input logic bad);
        logic [31:0] r;
        logic        is_last;
        logic        forwarded;
        // oversize and bad frames never reach the output
        forwarded = (len <= 2 ** `FIFO_ADDR_WIDTH) && !bad;
        if (len > 2 ** `FIFO_ADDR_WIDTH) begin
            exp_dropped++;
        end else if (bad) begin
            exp_bad++;
        end else begin
            exp_good++;
        end
        for (int i = 0; i < len; i++) begin
            draw(r);
            is_last = (i == len - 1);
            tick();
            in_valid <= 1'b1;
            in_data  <= r[`FIFO_DATA_WIDTH-1:0];
            in_last  <= is_last;
            // user only matters on the last beat
            in_user  <= is_last ? bad : r[8];
            if (forwarded) begin
                ref_q.push_back({is_last, r[`FIFO_DATA_WIDTH-1:0]});
            end
            beats_sent++;
        end
        tick();
        in_valid <= 1'b0;
        in_last  <= 1'b0;
        in_user  <= 1'b0;
    endtask

    // wait until the output has stayed idle for a few clocks
    task automatic drain();
        int idle_cycles;
        idle_cycles = 0;
        while (idle_cycles < 4) begin
            tick();
            if (out_valid) begin
                idle_cycles = 0;
            end else begin
                idle_cycles++;
            end
        end
    endtask

    // compare every transfer with the head of the queue
    always @(posedge clk) begin : monitor
        logic [`FIFO_DATA_WIDTH:0] exp_beat;
        if (!rst && out_valid && out_ready) begin
            if (ref_q.size() == 0) begin
                $display("output beat %0h at %0t ns arrived with no frame expected",
                         out_data, $time);
                check_errors++;
            end else begin
                exp_beat = ref_q.pop_front();
                assert (out_data == exp_beat[`FIFO_DATA_WIDTH-1:0])
                    else report_mismatch("out_data", exp_beat[`FIFO_DATA_WIDTH-1:0], out_data);
                assert (out_last == exp_beat[`FIFO_DATA_WIDTH])
                    else report_mismatch("out_last", exp_beat[`FIFO_DATA_WIDTH], out_last);
            end
        end
    end

    // limit grows with the traffic since each beat crosses in and out
    initial begin : watchdog
        while (cycle_count <= 2 * beats_sent + stall_cycles + 200) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d clock periods, output did not drain", cycle_count);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] r;
        clk       = 1'b0;
        rst       = 1'b1;
        in_data   = '0;
        in_valid  = 1'b0;
        in_last   = 1'b0;
        in_user   = 1'b0;
        out_ready = 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        repeat (4) tick();

        // back-to-back frames with the output draining
        for (int f = 0; f < 24; f++) begin
            draw(r);
            if (f % 8 == 5) begin
                send_frame(20, 1'b0);
            end else begin
                send_frame(1 + r % 12, (r[8:7] == 2'b00) || (f % 8 == 2));
            end
        end
        drain();

        // random back-pressure with one frame in flight at a time
        ready_random = 1'b1;
        for (int f = 0; f < 16; f++) begin
            draw(r);
            send_frame(1 + r % 12, r[9:8] == 2'b00);
            drain();
        end
        ready_random = 1'b0;
        drain();
        // counters trail the last beat by two edges
        repeat (4) tick();

        assert (good_frames == exp_good)
            else report_mismatch("good_frames", exp_good, good_frames);
        assert (bad_frames == exp_bad)
            else report_mismatch("bad_frames", exp_bad, bad_frames);
        assert (dropped_frames == exp_dropped)
            else report_mismatch("dropped_frames", exp_dropped, dropped_frames);
        assert (ref_q.size() == 0)
            else report_mismatch("ref_q size", 0, ref_q.size());

        $display("errors: checks=%0d assertions=%0d", check_errors,
                 DUT.u_assert.assert_failures);
        if (check_errors == 0 && DUT.u_assert.assert_failures == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
